// ==== hw/sample_pkg.sv ====
// lane geometry, signed sample type, sample bus and per-lane flag types
`default_nettype none

package sample_pkg;

   localparam int n_lanes         = 40;   // samples delivered per clklvds cycle
   localparam int lanes_per_group = 10;   // channels interleave in groups of ten
   localparam int sample_w        = 12;   // adc resolution

   typedef logic signed [sample_w-1:0] sample_t;   // one adc sample, two's complement

   typedef sample_t [n_lanes-1:0] sample_bus_t;   // lane k sits at index k

   typedef logic [n_lanes-1:0] lane_mask_t;   // one bit per lane

   // threshold crossings, already masked by channel selection
   typedef struct packed {
      lane_mask_t below;   // sample under the lower threshold
      lane_mask_t above;   // sample over the upper threshold
   } lane_flags_t;

endpackage

`default_nettype wire

// ==== hw/acq_types_pkg.sv ====
// trigger opcodes, acquisition states, configuration and threshold structs
`default_nettype none

package acq_types_pkg;

   // trigger opcodes as written by software
   typedef enum logic [7:0] {
      trig_off     = 8'd0,
      trig_rising  = 8'd1,
      trig_falling = 8'd2,
      trig_auto    = 8'd4
   } trig_type_e;

   // state codes, kept compatible with the readout software
   typedef enum logic [7:0] {
      st_idle       = 8'd0,     // waiting for a trigger type
      st_arm_low    = 8'd1,     // first edge step
      st_arm_high   = 8'd2,     // second edge step, holdoff and tot
      st_auto_fire  = 8'd6,     // unconditional capture
      st_pre_acq    = 8'd200,   // filling the pre-trigger window
      st_delay_wait = 8'd242,   // trigger delay
      st_post_acq   = 8'd250,   // filling the post-trigger window
      st_done       = 8'd251    // waiting for readout
   } acq_state_e;

   typedef struct packed {
      trig_type_e  trig_type;
      logic        chan_sel;     // channel to trigger on in two-channel mode
      logic        two_chan;     // lanes split into two channels
      logic [7:0]  tot;          // time over threshold, in write strobes
      logic [7:0]  holdoff;      // quiet strobes needed before an edge counts
      logic [7:0]  delay;        // strobes between trigger and fire
      logic [4:0]  downsample;   // write once every 2^downsample cycles
      logic [15:0] prelength;    // strobes before the trigger
      logic [15:0] length;       // strobes after the trigger
   } acq_cfg_t;

   typedef struct packed {
      sample_pkg::sample_t lower;
      sample_pkg::sample_t upper;
   } thresh_t;

endpackage

`default_nettype wire

// ==== hw/lane_compare.sv ====
// lane_compare: registered per-lane threshold compare with channel masking
`timescale 1ns/1ps
`default_nettype none

module lane_compare (
   input  wire logic                    clklvds,
   input  wire logic                    reset,
   input  wire sample_pkg::sample_bus_t samples,
   input  wire acq_types_pkg::thresh_t  thresholds,
   input  wire logic                    two_chan,
   input  wire logic                    chan_sel,
   output sample_pkg::lane_flags_t      flags       // one cycle after samples
);

   sample_pkg::lane_mask_t  lane_en;   // lanes of the channel we trigger on
   sample_pkg::lane_flags_t flags_d;

   // groups 0 and 2 carry channel 0, groups 1 and 3 carry channel 1
   always_comb begin
      for (int k = 0; k < sample_pkg::n_lanes; k++) begin
         lane_en[k] = !two_chan ||
                      (((k / sample_pkg::lanes_per_group) % 2) == int'(chan_sel));
      end
   end

   always_comb begin
      for (int k = 0; k < sample_pkg::n_lanes; k++) begin
         // signed compare, samples are two's complement
         flags_d.below[k] = lane_en[k] &&
                            ($signed(samples[k]) < $signed(thresholds.lower));
         flags_d.above[k] = lane_en[k] &&
                            ($signed(samples[k]) > $signed(thresholds.upper));
      end
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         flags <= '0;          // no crossings out of reset
      end
      else begin
         flags <= flags_d;     // decode stage register
      end
   end

endmodule

`default_nettype wire

// ==== hw/write_pacer.sv ====
// write_pacer: downsample pacing, ram write strobe and ram write address
`timescale 1ns/1ps
`default_nettype none

module write_pacer #(
   parameter int addr_w = 10
) (
   input  wire logic              clklvds,
   input  wire logic              reset,
   input  wire logic              armed,            // state being entered is armed
   input  wire logic [4:0]        downsample,
   output logic                   wr_tick,          // strobe seen by the fsm
   output logic                   ram_wr,
   output logic [addr_w-1:0]      ram_wr_address    // counts strobes since reset
);

   logic [31:0] pace_cnt;      // cycles left until the next strobe
   logic [31:0] pace_reload;   // 2^downsample - 1
   logic        armed_q;       // for rising edge of armed

   assign pace_reload = (32'd1 << downsample) - 32'd1;
   assign wr_tick     = ram_wr;   // the fsm counts the write itself

   always_ff @(posedge clklvds) begin
      if (reset) begin
         pace_cnt       <= '0;
         armed_q        <= 1'b0;
         ram_wr         <= 1'b0;
         ram_wr_address <= '0;
      end
      else begin
         armed_q <= armed;
         ram_wr  <= 1'b0;                            // strobe is one cycle wide
         if (armed && !armed_q) begin
            pace_cnt <= pace_reload;                 // fresh period on arming
         end
         else if (armed) begin
            if (pace_cnt == '0) begin
               pace_cnt       <= pace_reload;
               ram_wr         <= 1'b1;
               ram_wr_address <= ram_wr_address + 1'b1;   // wraps around the ring
            end
            else begin
               pace_cnt <= pace_cnt - 32'd1;
            end
         end
      end
   end

   // armed leads the state by one cycle, so every write lands inside an armed state
   wr_only_armed: assert property (@(posedge clklvds) disable iff (reset)
      ram_wr |-> $past(armed))
      else $error("ram_wr outside an armed state");

endmodule

`default_nettype wire

// ==== hw/acq_fsm.sv ====
// acq_fsm: acquisition state machine with holdoff, tot, delay and length counters
`timescale 1ns/1ps
`default_nettype none

module acq_fsm #(
   parameter int addr_w = 10
) (
   input  wire logic                     clklvds,
   input  wire logic                     reset,
   input  wire acq_types_pkg::acq_cfg_t  cfg,
   input  wire sample_pkg::lane_flags_t  flags,
   input  wire logic                     wr_tick,
   input  wire logic                     readout,
   output logic                          armed,        // from the next state
   output logic                          fire,         // first cycle of post_acq
   output logic                          done_entry,   // first cycle of done
   output sample_pkg::lane_mask_t        hit_mask,
   output acq_types_pkg::acq_state_e     state
);

   acq_types_pkg::acq_state_e state_d;
   acq_types_pkg::trig_type_e act_type;     // type latched when leaving idle
   acq_types_pkg::trig_type_e act_type_d;
   logic [15:0]               acq_cnt;      // pre and post window strobes
   logic [15:0]               acq_cnt_d;
   logic [7:0]                holdoff_cnt;  // quiet strobes, saturating
   logic [7:0]                holdoff_cnt_d;
   logic [7:0]                tot_cnt;      // consecutive passing strobes
   logic [7:0]                tot_cnt_d;
   logic [7:0]                delay_cnt;
   logic [7:0]                delay_cnt_d;
   sample_pkg::lane_mask_t    hit_mask_d;
   sample_pkg::lane_mask_t    first_step;   // below for rising, above for falling
   sample_pkg::lane_mask_t    second_step;
   logic                      rising;
   logic                      pre_last;     // pre window full, counting this strobe
   logic                      post_last;

   assign rising      = (act_type == acq_types_pkg::trig_rising);
   assign first_step  = rising ? flags.below : flags.above;
   assign second_step = rising ? flags.above : flags.below;
   assign pre_last    = ({1'b0, acq_cnt} + {16'd0, wr_tick}) >= {1'b0, cfg.prelength};
   assign post_last   = ({1'b0, acq_cnt} + {16'd0, wr_tick}) >= {1'b0, cfg.length};

   always_comb begin
      state_d       = state;
      act_type_d    = act_type;
      acq_cnt_d     = wr_tick ? acq_cnt + 16'd1 : acq_cnt;
      holdoff_cnt_d = holdoff_cnt;
      tot_cnt_d     = tot_cnt;
      delay_cnt_d   = delay_cnt;
      hit_mask_d    = hit_mask;
      case (state)
         acq_types_pkg::st_idle: begin
            holdoff_cnt_d = '0;
            tot_cnt_d     = '0;
            act_type_d    = cfg.trig_type;
            if (cfg.trig_type != acq_types_pkg::trig_off) state_d = acq_types_pkg::st_pre_acq;
         end
         acq_types_pkg::st_pre_acq: begin
            if (pre_last) begin
               if (act_type == acq_types_pkg::trig_auto) state_d = acq_types_pkg::st_auto_fire;
               else state_d = acq_types_pkg::st_arm_low;
            end
         end
         acq_types_pkg::st_arm_low: begin
            tot_cnt_d = '0;
            if (|first_step) state_d = acq_types_pkg::st_arm_high;   // first edge step seen
         end
         acq_types_pkg::st_arm_high: begin
            if (!(|second_step)) begin
               tot_cnt_d = '0;                                       // tot must be consecutive
               if (wr_tick && holdoff_cnt != 8'hff) holdoff_cnt_d = holdoff_cnt + 8'd1;
            end
            else if (holdoff_cnt < cfg.holdoff) begin
               holdoff_cnt_d = '0;                                   // crossed too soon
               state_d       = acq_types_pkg::st_arm_low;
            end
            else begin
               if (wr_tick) tot_cnt_d = tot_cnt + 8'd1;
               if (tot_cnt >= cfg.tot) begin
                  hit_mask_d = second_step;                          // lanes that made it
                  if (cfg.delay == 8'd0) state_d = acq_types_pkg::st_post_acq;
                  else state_d = acq_types_pkg::st_delay_wait;
               end
            end
         end
         acq_types_pkg::st_delay_wait: begin
            if (delay_cnt >= cfg.delay) state_d = acq_types_pkg::st_post_acq;
            else if (wr_tick) delay_cnt_d = delay_cnt + 8'd1;
         end
         acq_types_pkg::st_auto_fire: begin
            hit_mask_d = '0;                                         // no edge measured
            state_d    = acq_types_pkg::st_post_acq;
         end
         acq_types_pkg::st_post_acq: begin
            if (post_last) state_d = acq_types_pkg::st_done;         // last write of window
         end
         acq_types_pkg::st_done: begin
            if (readout) state_d = acq_types_pkg::st_idle;
         end
         default: state_d = acq_types_pkg::st_idle;
      endcase
      // a new trigger type while armed abandons the acquisition
      if (state != acq_types_pkg::st_idle && state != acq_types_pkg::st_done &&
          cfg.trig_type != act_type) begin
         state_d = acq_types_pkg::st_idle;
      end
      if (state_d != state) begin
         acq_cnt_d   = '0;   // each window starts from zero
         delay_cnt_d = '0;
      end
   end

   // the pacer sees the state being entered
   assign armed = (state_d != acq_types_pkg::st_idle) && (state_d != acq_types_pkg::st_done);

   always_ff @(posedge clklvds) begin
      if (reset) begin
         state       <= acq_types_pkg::st_idle;
         act_type    <= acq_types_pkg::trig_off;
         acq_cnt     <= '0;
         holdoff_cnt <= '0;
         tot_cnt     <= '0;
         delay_cnt   <= '0;
         fire        <= 1'b0;
         done_entry  <= 1'b0;
      end
      else begin
         state       <= state_d;
         act_type    <= act_type_d;
         acq_cnt     <= acq_cnt_d;
         holdoff_cnt <= holdoff_cnt_d;
         tot_cnt     <= tot_cnt_d;
         delay_cnt   <= delay_cnt_d;
         fire        <= (state_d == acq_types_pkg::st_post_acq) &&
                        (state != acq_types_pkg::st_post_acq);
         done_entry  <= (state_d == acq_types_pkg::st_done) && (state != acq_types_pkg::st_done);
      end
   end

   always_ff @(posedge clklvds) begin
      hit_mask <= hit_mask_d;   // held from the trigger decision until fire
   end

   fire_single: assert property (@(posedge clklvds) disable iff (reset)
      fire |=> !fire)
      else $error("fire wider than one cycle");

   fire_source: assert property (@(posedge clklvds) disable iff (reset)
      fire |-> $past(state) inside {acq_types_pkg::st_arm_high, acq_types_pkg::st_delay_wait,
                                    acq_types_pkg::st_auto_fire})
      else $error("fire from an unexpected state");

   // pre and post windows together must fit in the ram ring
   window_fits: assert property (@(posedge clklvds) disable iff (reset)
      (state == acq_types_pkg::st_idle && state_d == acq_types_pkg::st_pre_acq)
         |-> (32'(cfg.prelength) + 32'(cfg.length) <= 2 ** addr_w))
      else $error("acquisition window longer than the ram");

endmodule

`default_nettype wire

// ==== hw/event_record.sv ====
// event_record: trigger address and hit mask latch, trig_fire pulse, event counter
`timescale 1ns/1ps
`default_nettype none

module event_record #(
   parameter int addr_w = 10
) (
   input  wire logic                   clklvds,
   input  wire logic                   reset,
   input  wire logic                   fire,
   input  wire logic                   done_entry,
   input  wire logic [addr_w-1:0]      wr_addr,
   input  wire logic [7:0]             tot,
   input  wire sample_pkg::lane_mask_t hit_mask,
   output logic [addr_w-1:0]           trig_addr,
   output sample_pkg::lane_mask_t      trig_hits,
   output logic [31:0]                 event_count,
   output logic                        trig_fire      // one cycle after fire
);

   always_ff @(posedge clklvds) begin
      if (reset) begin
         trig_fire   <= 1'b0;
         event_count <= '0;
      end
      else begin
         trig_fire <= fire;
         if (done_entry) begin
            event_count <= event_count + 32'd1;   // one per completed acquisition
         end
      end
   end

   always_ff @(posedge clklvds) begin
      if (fire) begin
         // step back over the tot strobes to where the edge started
         trig_addr <= wr_addr - addr_w'(tot);
         trig_hits <= hit_mask;
      end
   end

endmodule

`default_nettype wire

// ==== hw/trigger_top.sv ====
// trigger_top: decode, execute and result stages with the write pacer
`timescale 1ns/1ps
`default_nettype none

module trigger_top #(
   parameter int addr_w = 10   // ram depth is 2^addr_w
) (
   input  wire logic                    clklvds,
   input  wire logic                    reset,
   input  wire sample_pkg::sample_bus_t samples,
   input  wire acq_types_pkg::thresh_t  thresholds,
   input  wire acq_types_pkg::acq_cfg_t cfg,
   input  wire logic                    readout,       // one-cycle strobe
   output logic                         ram_wr,
   output logic [addr_w-1:0]            ram_wr_address,
   output logic                         trig_fire,
   output logic [addr_w-1:0]            trig_addr,
   output sample_pkg::lane_mask_t       trig_hits,
   output logic [31:0]                  event_count,
   output logic                         acq_done,      // ready for readout
   output acq_types_pkg::acq_state_e    acq_state
);

   sample_pkg::lane_flags_t flags;        // decode to execute
   sample_pkg::lane_mask_t  hit_mask;     // execute to result
   logic                    armed;
   logic                    wr_tick;
   logic                    fire;
   logic                    done_entry;

   assign acq_done = (acq_state == acq_types_pkg::st_done);

   lane_compare lane_compare_i (
      .clklvds    (clklvds),
      .reset      (reset),
      .samples    (samples),
      .thresholds (thresholds),
      .two_chan   (cfg.two_chan),
      .chan_sel   (cfg.chan_sel),
      .flags      (flags)
   );

   write_pacer #(.addr_w(addr_w)) write_pacer_i (
      .clklvds        (clklvds),
      .reset          (reset),
      .armed          (armed),
      .downsample     (cfg.downsample),
      .wr_tick        (wr_tick),
      .ram_wr         (ram_wr),
      .ram_wr_address (ram_wr_address)
   );

   acq_fsm #(.addr_w(addr_w)) acq_fsm_i (
      .clklvds    (clklvds),
      .reset      (reset),
      .cfg        (cfg),
      .flags      (flags),
      .wr_tick    (wr_tick),
      .readout    (readout),
      .armed      (armed),
      .fire       (fire),
      .done_entry (done_entry),
      .hit_mask   (hit_mask),
      .state      (acq_state)
   );

   event_record #(.addr_w(addr_w)) event_record_i (
      .clklvds     (clklvds),
      .reset       (reset),
      .fire        (fire),
      .done_entry  (done_entry),
      .wr_addr     (ram_wr_address),
      .tot         (cfg.tot),
      .hit_mask    (hit_mask),
      .trig_addr   (trig_addr),
      .trig_hits   (trig_hits),
      .event_count (event_count),
      .trig_fire   (trig_fire)
   );

endmodule

`default_nettype wire

// ==== verif/trigger_checks.svh ====
// compare tasks for ram addresses, lane masks, counters and fsm states
`ifndef TRIGGER_CHECKS_SVH
`define TRIGGER_CHECKS_SVH

// address compare, ram_wr_address and trig_addr
task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                          input logic [addr_w-1:0] exp);
   if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
   end
endtask

// lane mask compare, same width as one lane_flags_t field
task automatic check_hits(input string name, input sample_pkg::lane_mask_t got,
                          input sample_pkg::lane_mask_t exp);
   if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%010h, expected 0x%010h", name, got, exp));
   end
endtask

// 32-bit counters
task automatic check_count(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
   if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
   end
endtask

// fsm state, printed as the raw code and the name
task automatic check_state(input string name, input acq_types_pkg::acq_state_e got,
                           input acq_types_pkg::acq_state_e exp);
   if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%0h (%s), expected 0x%0h (%s)",
                         name, got, got.name(), exp, exp.name()));
   end
endtask

`endif

// ==== verif/trigger_tb.sv ====
// trigger_tb: clock, reset, golden file reader, stimulus and scoreboard for trigger_top
`timescale 1ns/1ps
`default_nettype none

module trigger_tb;

   localparam int addr_w  = 10;
   localparam int n_field = 19;   // values per golden line

   logic                      clklvds;
   logic                      reset;
   sample_pkg::sample_bus_t   samples;
   acq_types_pkg::thresh_t    thresholds;
   acq_types_pkg::acq_cfg_t   cfg;
   logic                      readout;
   logic                      ram_wr;
   logic [addr_w-1:0]         ram_wr_address;
   logic                      trig_fire;
   logic [addr_w-1:0]         trig_addr;
   sample_pkg::lane_mask_t    trig_hits;
   logic [31:0]               event_count;
   logic                      acq_done;
   acq_types_pkg::acq_state_e acq_state;

   integer                 seed = 19967;   // $random seed
   logic [63:0]            fld [n_field];  // one golden line
   sample_pkg::lane_mask_t cross_lanes;    // lanes that get the case value
   sample_pkg::lane_mask_t exp_hits;
   logic [addr_w-1:0]      exp_addr;       // strobes since reset, wrapped
   logic [addr_w-1:0]      prev_addr;      // exp_addr one cycle back, the fire cycle
   int                     cycle;
   int                     last_strobe;    // -1 until the first strobe of a case
   int                     phase_strobes;
   int                     case_strobes;
   int                     post_strobes;   // strobes seen in post_acq
   int                     fire_cnt;
   bit                     fire_ok;        // trig_fire allowed now

   trigger_top #(.addr_w(addr_w)) dut_i (
      .clklvds(clklvds), .reset(reset), .samples(samples), .thresholds(thresholds),
      .cfg(cfg), .readout(readout), .ram_wr(ram_wr), .ram_wr_address(ram_wr_address),
      .trig_fire(trig_fire), .trig_addr(trig_addr), .trig_hits(trig_hits),
      .event_count(event_count), .acq_done(acq_done), .acq_state(acq_state)
   );

   `include "trigger_checks.svh"

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   // new samples, case lanes get val, the rest random inside the thresholds
   task automatic drive_lanes(input sample_pkg::sample_t val);
      int lo;
      int hi;
      lo = $signed(thresholds.lower);
      hi = $signed(thresholds.upper);
      for (int k = 0; k < sample_pkg::n_lanes; k++) begin
         if (cross_lanes[k]) begin
            samples[k] = val;
         end
         else begin
            samples[k] = sample_pkg::sample_t'(lo + 1 +
                         int'($unsigned($random(seed)) % (hi - lo - 1)));
         end
      end
   endtask

   // one clock, outputs sampled 1 ns after the edge, scoreboard updated
   task automatic step_cycle();
      @(posedge clklvds);
      #1;
      cycle++;
      prev_addr = exp_addr;
      if (ram_wr) begin
         exp_addr = exp_addr + 1'b1;
         phase_strobes++;
         case_strobes++;
         if (acq_state == acq_types_pkg::st_post_acq) post_strobes++;
         if (last_strobe >= 0 && (cycle - last_strobe) != (1 << cfg.downsample))
            fail_run($sformatf("write strobes %0d cycles apart with downsample %0d",
                               cycle - last_strobe, cfg.downsample));
         last_strobe = cycle;
      end
      check_addr("ram_wr_address", ram_wr_address, exp_addr);
      if (acq_done && ram_wr) fail_run("ram_wr pulsed while acq_done was high");
      if (trig_fire) begin
         if (!fire_ok) fail_run("trig_fire came while no trigger was expected");
         fire_cnt++;
         check_addr("trig_addr", trig_addr, prev_addr - addr_w'(cfg.tot));   // fire cycle - tot
         check_hits("trig_hits", trig_hits, exp_hits);
      end
   endtask

   // hold val on the case lanes for n write strobes
   task automatic run_phase(input sample_pkg::sample_t val, input int n, input string what);
      int guard;
      guard = 0;
      phase_strobes = 0;
      drive_lanes(val);
      while (phase_strobes < n) begin
         guard++;
         if (guard > ((n + 2) << cfg.downsample) + 40)
            fail_run({"the ", what, " phase never got its write strobes"});
         step_cycle();
         drive_lanes(val);
      end
   endtask

   task automatic wait_fire(input sample_pkg::sample_t val, input int limit);
      int guard;
      guard = 0;
      drive_lanes(val);
      step_cycle();
      while (!trig_fire) begin
         drive_lanes(val);
         guard++;
         if (guard > limit) fail_run("trig_fire never came");
         step_cycle();
      end
   endtask

   task automatic wait_done(input sample_pkg::sample_t val, input int limit);
      int guard;
      guard = 0;
      while (!acq_done) begin
         drive_lanes(val);
         guard++;
         if (guard > limit) fail_run("acq_done never came after trig_fire");
         step_cycle();
      end
   endtask

   task automatic play_case();
      sample_pkg::sample_t quiet_v;
      sample_pkg::sample_t arm_v;
      sample_pkg::sample_t cross_v;
      int                  cross_start;
      int                  limit;
      quiet_v = fld[11][11:0];
      arm_v   = fld[12][11:0];
      cross_v = fld[13][11:0];
      cfg.trig_type  = acq_types_pkg::trig_type_e'(fld[0][7:0]);   // set while idle
      cfg.downsample = fld[1][4:0];
      cfg.chan_sel   = fld[2][0];
      cfg.two_chan   = fld[3][0];
      cfg.tot        = fld[4][7:0];
      cfg.holdoff    = fld[5][7:0];
      cfg.delay      = fld[6][7:0];
      cfg.prelength  = fld[7][15:0];
      cfg.length     = fld[8][15:0];
      thresholds.lower = fld[9][11:0];
      thresholds.upper = fld[10][11:0];
      cross_lanes = fld[14][39:0];
      exp_hits    = fld[17][39:0];
      last_strobe  = -1;
      case_strobes = 0;
      post_strobes = 0;
      fire_cnt     = 0;
      fire_ok      = 1'b0;
      limit = ((int'(cfg.prelength) + cfg.tot + cfg.delay + cfg.holdoff + 16)
               << cfg.downsample) + 64;
      if (cfg.trig_type == acq_types_pkg::trig_auto) begin
         fire_ok = 1'b1;
         wait_fire(quiet_v, limit);
         if (case_strobes < int'(cfg.prelength))
            fail_run("auto trigger fired before prelength strobes");
      end
      else begin
         run_phase(quiet_v, int'(fld[15]), "quiet");
         if (int'(fld[16]) + 1 < int'(cfg.holdoff)) begin   // crossing inside the holdoff window
            run_phase(arm_v, int'(fld[16]), "arming");
            run_phase(cross_v, cfg.tot + cfg.delay + 4, "early crossing");
            run_phase(arm_v, cfg.holdoff + 3, "re-arming");
         end
         else run_phase(arm_v, int'(fld[16]), "arming");
         fire_ok     = 1'b1;
         cross_start = case_strobes;
         wait_fire(cross_v, limit);
         if (case_strobes - cross_start < int'(cfg.delay))
            fail_run("trig_fire came before the delay ran out");
      end
      fire_ok = 1'b0;
      wait_done(quiet_v, ((int'(cfg.length) + 4) << cfg.downsample) + 50);
      check_state("acq_state", acq_state, acq_types_pkg::st_done);
      check_count("post-trigger strobes", 32'(post_strobes), 32'(cfg.length));
      repeat (4) begin   // done must hold until readout
         step_cycle();
         drive_lanes(quiet_v);
         if (!acq_done) fail_run("acq_done dropped before the readout strobe");
         check_state("acq_state", acq_state, acq_types_pkg::st_done);
      end
      readout       = 1'b1;
      cfg.trig_type = acq_types_pkg::trig_off;   // stay in idle after readout
      step_cycle();
      readout = 1'b0;
      drive_lanes(quiet_v);
      if (acq_done) fail_run("acq_done still high after the readout strobe");
      check_state("acq_state", acq_state, acq_types_pkg::st_idle);
      check_count("event_count", event_count, fld[18][31:0]);
      if (fire_cnt != 1) fail_run($sformatf("trig_fire pulsed %0d times in one case", fire_cnt));
   endtask

   initial begin
      clklvds = 1'b0;
      forever #2 clklvds = ~clklvds;   // 4 ns period
   end

   initial begin
      int    fd;
      int    n;
      int    n_cases;
      string line;
      reset            = 1'b1;
      readout          = 1'b0;
      samples          = '0;
      cfg              = '0;
      thresholds.lower = -12'sd200;
      thresholds.upper = 12'sd200;
      cross_lanes      = '0;
      exp_hits         = '0;
      exp_addr         = '0;
      prev_addr        = '0;
      cycle            = 0;
      last_strobe      = -1;
      fire_ok          = 1'b0;
      n_cases          = 0;
      repeat (2) @(posedge clklvds);
      #1;
      reset = 1'b0;
      step_cycle();
      check_state("acq_state", acq_state, acq_types_pkg::st_idle);
      check_count("event_count", event_count, 32'd0);
      if (ram_wr || trig_fire || acq_done)
         fail_run("ram_wr, trig_fire or acq_done high after reset");
      fd = $fopen("verif/trigger_golden.txt", "r");
      if (fd == 0) fail_run("could not open verif/trigger_golden.txt");
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 3 || line.getc(0) == 8'h23) continue;   // blank or column notes
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                     fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
                     fld[17], fld[18]);
         if (n != n_field) fail_run({"malformed golden line: ", line});
         n_cases++;
         play_case();
      end
      $fclose(fd);
      if (n_cases == 0) begin
         fail_run("golden file holds no cases");
      end
      else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== verif/trigger_golden.txt ====
# type ds chan_sel two_chan tot holdoff delay prelength length lower upper quiet arming crossing
#   lanes quiet_strobes arming_strobes exp_hits exp_count  (hex, samples 12-bit two's complement)
1 0 0 0 00 00 00 000a 000c f38 0c8 000 e0c 1f4 00000000f3 0e 04 00000000f3 1
1 1 1 1 02 02 00 0008 0010 f38 0c8 000 e0c 1f4 0000c03c01 0c 06 0000003c00 2
2 0 0 1 01 01 00 0006 0014 f38 0c8 000 1f4 e0c ff000003ff 09 04 00000003ff 3
1 0 0 0 00 08 00 000c 000a f38 0c8 000 e0c 1f4 8000000001 0f 03 8000000001 4
4 2 0 0 00 00 00 0014 0010 f38 0c8 000 000 000 0000000000 00 00 0000000000 5
1 3 0 0 01 00 03 0005 0008 f38 0c8 000 e0c 1f4 0f0f0f0f0f 08 03 0f0f0f0f0f 6
2 0 0 0 00 04 02 0007 0020 f38 0c8 000 1f4 e0c 00ffff0000 0a 07 00ffff0000 7
4 0 0 0 05 00 00 0004 001e f38 0c8 000 000 000 0000000000 00 00 0000000000 8

// ==== sim.f ====
hw/sample_pkg.sv
hw/acq_types_pkg.sv
hw/lane_compare.sv
hw/write_pacer.sv
hw/acq_fsm.sv
hw/event_record.sv
hw/trigger_top.sv
+incdir+verif
verif/trigger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build trigger_tb with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module trigger_tb \
      -o trigger_sim \
   && ./obj_dir/trigger_sim | tee /dev/stderr | grep -qx "RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
